/* project.f */
src/fetch_pkg.sv
src/next_pc_select.sv
src/pc_register.sv
src/instr_memory.sv
src/if_id_register.sv
src/instruction_fetch.sv
testbench/fetch_props.sv
testbench/tb_instruction_fetch.sv

/* src/fetch_pkg.sv */
package fetch_pkg;

	////////////////////
	// Widths and sizes
	////////////////////

	// Data and address width of the core
	localparam int WORD_W = 32;

	// Instruction words held in the fetch RAM
	localparam int MEM_DEPTH = 2048;

	// Index width into the RAM
	localparam int ADDR_W = $clog2(MEM_DEPTH);

	////////////////////
	// Next-PC source
	////////////////////

	// Every value other than PC_SEQ redirects the stream
	typedef enum logic [2:0]
	{
		PC_SEQ    = 3'd0,
		PC_JUMP   = 3'd1,
		PC_BRANCH = 3'd2,
		PC_REG    = 3'd3
	} pc_src_t;

	////////////////////
	// Special words
	////////////////////

	// Halt instruction, all ones
	localparam logic [WORD_W-1:0] HALT_WORD = '1;

	// Bubble sent to decode after a redirect
	localparam logic [WORD_W-1:0] NOP_WORD = '0;

endpackage

/* src/if_id_register.sv */
`timescale 1ns/1ps

module if_id_register
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         stall,
	input  logic                         flush,
	input  logic [fetch_pkg::WORD_W-1:0] instr,
	input  logic [fetch_pkg::WORD_W-1:0] fetch_pc,
	output logic [fetch_pkg::WORD_W-1:0] id_instr,
	output logic [fetch_pkg::WORD_W-1:0] id_pc,
	output logic [fetch_pkg::WORD_W-1:0] id_pc_plus1
);

	import fetch_pkg::*;

	// Marks the word read on the redirect edge as wrong-path
	logic kill;

	////////////////////
	// IF/ID stage
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			kill        <= 1'b0;
			id_instr    <= NOP_WORD;
			id_pc       <= '0;
			id_pc_plus1 <= '0;
		end
		else if (!stall)
		begin
			kill <= flush;
			if (kill)
			begin
				// Bubble in place of the old-path word
				id_instr    <= NOP_WORD;
				id_pc       <= '0;
				id_pc_plus1 <= '0;
			end
			else
			begin
				id_instr    <= instr;
				id_pc       <= fetch_pc;
				id_pc_plus1 <= fetch_pc + WORD_W'(1);
			end
		end
	end

endmodule

/* src/instr_memory.sv */
`timescale 1ns/1ps

module instr_memory
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic [fetch_pkg::WORD_W-1:0] rd_addr,
	input  logic                         rd_en,
	input  logic                         wr_en,
	input  logic [fetch_pkg::WORD_W-1:0] wr_addr,
	input  logic [fetch_pkg::WORD_W-1:0] wr_data,
	output logic [fetch_pkg::WORD_W-1:0] instr,
	output logic                         halted
);

	import fetch_pkg::*;

	logic [WORD_W-1:0] mem [MEM_DEPTH];

	logic [ADDR_W-1:0] rd_idx;
	logic [ADDR_W-1:0] wr_idx;

	logic halt_seen;
	logic halt_now;

	// Word addressed; upper address bits are ignored
	assign rd_idx = rd_addr[ADDR_W-1:0];
	assign wr_idx = wr_addr[ADDR_W-1:0];

	////////////////////
	// Debug write port
	////////////////////

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_idx] <= wr_data;
		end
	end

	////////////////////
	// Read port
	////////////////////

	// One cycle of latency; a write cycle skips the read
	// Output comes up as a bubble so decode sees no garbage
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			instr <= NOP_WORD;
		end
		else if (rd_en && !wr_en)
		begin
			instr <= mem[rd_idx];
		end
	end

	////////////////////
	// Halt detection
	////////////////////

	assign halt_now = (instr == HALT_WORD);

	// Sticky until reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			halt_seen <= 1'b0;
		end
		else if (halt_now)
		begin
			halt_seen <= 1'b1;
		end
	end

	// Visible right after the edge that read the halt word,
	// so the PC freezes on the very next edge
	assign halted = halt_seen || halt_now;

endmodule

/* src/instruction_fetch.sv */
`timescale 1ns/1ps

module instruction_fetch
(
	input  logic                         clk,
	input  logic                         rst,
	input  fetch_pkg::pc_src_t           pc_src,
	input  logic [fetch_pkg::WORD_W-1:0] jump_target,
	input  logic [fetch_pkg::WORD_W-1:0] branch_target,
	input  logic [fetch_pkg::WORD_W-1:0] reg_target,
	input  logic                         stall,
	input  logic                         debug_en,
	input  logic [fetch_pkg::WORD_W-1:0] debug_addr,
	input  logic [fetch_pkg::WORD_W-1:0] debug_data,
	output logic [fetch_pkg::WORD_W-1:0] id_instr,
	output logic [fetch_pkg::WORD_W-1:0] id_pc,
	output logic [fetch_pkg::WORD_W-1:0] id_pc_plus1,
	output logic                         halted
);

	import fetch_pkg::*;

	logic [WORD_W-1:0] pc;
	logic [WORD_W-1:0] next_pc;
	logic [WORD_W-1:0] fetch_pc;
	logic [WORD_W-1:0] instr;
	logic              redirect;
	logic              pc_hold;
	logic              flush;

	// PC and RAM read freeze together
	assign pc_hold = stall || halted || debug_en;

	// A redirect only counts when the PC actually takes it
	assign flush = redirect && !pc_hold;

	////////////////////
	// Input side
	////////////////////

	next_pc_select u_next_pc_select
	(
		.pc            (pc),
		.pc_src        (pc_src),
		.jump_target   (jump_target),
		.branch_target (branch_target),
		.reg_target    (reg_target),
		.next_pc       (next_pc),
		.redirect      (redirect)
	);

	pc_register u_pc_register
	(
		.clk      (clk),
		.rst      (rst),
		.next_pc  (next_pc),
		.hold     (pc_hold),
		.pc       (pc),
		.fetch_pc (fetch_pc)
	);

	////////////////////
	// Memory
	////////////////////

	instr_memory u_instr_memory
	(
		.clk     (clk),
		.rst     (rst),
		.rd_addr (pc),
		.rd_en   (!pc_hold),
		.wr_en   (debug_en),
		.wr_addr (debug_addr),
		.wr_data (debug_data),
		.instr   (instr),
		.halted  (halted)
	);

	////////////////////
	// Output side
	////////////////////

	// Only an external stall freezes this stage, so the halt word reaches decode
	if_id_register u_if_id_register
	(
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.flush       (flush),
		.instr       (instr),
		.fetch_pc    (fetch_pc),
		.id_instr    (id_instr),
		.id_pc       (id_pc),
		.id_pc_plus1 (id_pc_plus1)
	);

endmodule

/* src/next_pc_select.sv */
`timescale 1ns/1ps

module next_pc_select
(
	input  logic [fetch_pkg::WORD_W-1:0] pc,
	input  fetch_pkg::pc_src_t           pc_src,
	input  logic [fetch_pkg::WORD_W-1:0] jump_target,
	input  logic [fetch_pkg::WORD_W-1:0] branch_target,
	input  logic [fetch_pkg::WORD_W-1:0] reg_target,
	output logic [fetch_pkg::WORD_W-1:0] next_pc,
	output logic                         redirect
);

	import fetch_pkg::*;

	logic [WORD_W-1:0] pc_plus1;

	// Word addressed, so the sequential step is one
	assign pc_plus1 = pc + WORD_W'(1);

	always_comb
	begin
		case (pc_src)
			PC_JUMP:
			begin
				next_pc = jump_target;
			end
			PC_BRANCH:
			begin
				next_pc = branch_target;
			end
			PC_REG:
			begin
				next_pc = reg_target;
			end
			// PC_SEQ and unused codes fall through
			default:
			begin
				next_pc = pc_plus1;
			end
		endcase
	end

	// Any taken target breaks the sequential stream
	assign redirect = (pc_src != PC_SEQ);

endmodule

/* src/pc_register.sv */
`timescale 1ns/1ps

module pc_register
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic [fetch_pkg::WORD_W-1:0] next_pc,
	input  logic                         hold,
	output logic [fetch_pkg::WORD_W-1:0] pc,
	output logic [fetch_pkg::WORD_W-1:0] fetch_pc
);

	import fetch_pkg::*;

	// Address of the word the RAM read on the last edge
	logic [WORD_W-1:0] pc_prev;

	////////////////////
	// Program counter
	////////////////////

	// Reset wins over hold, hold wins over update
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc      <= '0;
			pc_prev <= '0;
		end
		else if (!hold)
		begin
			pc      <= next_pc;
			// Same edge as the RAM read at pc
			pc_prev <= pc;
		end
	end

	assign fetch_pc = pc_prev;

endmodule

/* testbench/fetch_props.sv */
`timescale 1ns/1ps

module fetch_props
(
	input logic                         clk,
	input logic                         rst,
	input logic                         stall,
	input logic                         flush,
	input logic                         halted,
	input logic [fetch_pkg::WORD_W-1:0] pc,
	input logic [fetch_pkg::WORD_W-1:0] id_instr
);

	import fetch_pkg::*;

	// Read back by the testbench at the end of the run
	int assert_failures = 0;

	////////////////////
	// Fetch invariants
	////////////////////

	// PC leaves reset at address zero
	pc_after_reset: assert property (@(posedge clk) rst |=> pc == '0)
	else
	begin
		$error("pc is not zero after reset");
		assert_failures++;
	end

	// A stalled cycle leaves the decode word alone
	stall_holds_id: assert property (@(posedge clk) disable iff (rst)
		stall |=> $stable(id_instr))
	else
	begin
		$error("id_instr changed during a stall");
		assert_failures++;
	end

	// Sticky until reset
	halted_sticky: assert property (@(posedge clk) disable iff (rst)
		halted |=> halted)
	else
	begin
		$error("halted dropped without reset");
		assert_failures++;
	end

	// Old-path word becomes a bubble one edge after the taken redirect
	redirect_bubble: assert property (@(posedge clk) disable iff (rst)
		flush ##1 !stall |=> id_instr == NOP_WORD)
	else
	begin
		$error("no bubble on id_instr after a redirect");
		assert_failures++;
	end

endmodule

/* testbench/tb_instruction_fetch.sv */
`timescale 1ns/1ps

module tb_instruction_fetch;

	import fetch_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 16;
	localparam int PROG_WORDS   = 64;
	localparam int HALT_AT      = 10;
	// Five tests of roughly 110 cycles each, with wide margin
	localparam int CYCLE_LIMIT  = 4000;

	logic              clk;
	logic              rst;
	pc_src_t           pc_src;
	logic [WORD_W-1:0] jump_target;
	logic [WORD_W-1:0] branch_target;
	logic [WORD_W-1:0] reg_target;
	logic              stall;
	logic              debug_en;
	logic [WORD_W-1:0] debug_addr;
	logic [WORD_W-1:0] debug_data;
	logic [WORD_W-1:0] id_instr;
	logic [WORD_W-1:0] id_pc;
	logic [WORD_W-1:0] id_pc_plus1;
	logic              halted;

	// Copy of what the debug port wrote into the low words of the RAM
	logic [WORD_W-1:0] image [PROG_WORDS];

	logic [31:0] rng_state;
	int          next_addr;
	int          error_count;
	int          check_count;
	int          test_base;
	int          cycle_count = 0;

	instruction_fetch u_instruction_fetch
	(
		.clk           (clk),
		.rst           (rst),
		.pc_src        (pc_src),
		.jump_target   (jump_target),
		.branch_target (branch_target),
		.reg_target    (reg_target),
		.stall         (stall),
		.debug_en      (debug_en),
		.debug_addr    (debug_addr),
		.debug_data    (debug_data),
		.id_instr      (id_instr),
		.id_pc         (id_pc),
		.id_pc_plus1   (id_pc_plus1),
		.halted        (halted)
	);

	bind instruction_fetch fetch_props u_fetch_props
	(
		.clk      (clk),
		.rst      (rst),
		.stall    (stall),
		.flush    (flush),
		.halted   (halted),
		.pc       (pc),
		.id_instr (id_instr)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic tick();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// xorshift32
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Halt and bubble encodings stay reserved for chosen slots
	function automatic logic [WORD_W-1:0] program_word();
		logic [WORD_W-1:0] w;
		w = next_random();
		while (w == HALT_WORD || w == NOP_WORD)
		begin
			w = next_random();
		end
		return w;
	endfunction

	task automatic check_word(input string name, input logic [WORD_W-1:0] got,
		input logic [WORD_W-1:0] expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("[FAIL] %s: got %h, expected %h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("[FAIL] %s: got %h, expected %h at %0t", name, got, expected, $time);
		end
	endtask

	// Decode sees the word at addr with its own address
	task automatic match_fetched(input int addr);
		check_word("id_instr", id_instr, image[addr]);
		check_word("id_pc", id_pc, WORD_W'(addr));
		check_word("id_pc_plus1", id_pc_plus1, WORD_W'(addr + 1));
	endtask

	task automatic confirm_bubble();
		check_word("id_instr", id_instr, NOP_WORD);
		check_word("id_pc", id_pc, '0);
		check_word("id_pc_plus1", id_pc_plus1, '0);
	endtask

	task automatic write_word(input int addr, input logic [WORD_W-1:0] data);
		debug_en = 1'b1;
		debug_addr = WORD_W'(addr);
		debug_data = data;
		tick();
		debug_en = 1'b0;
	endtask

	// Loads under reset, so the stage restarts at address zero
	task automatic load_program(input int halt_addr);
		rst = 1'b1;
		stall = 1'b0;
		pc_src = PC_SEQ;
		for (int a = 0; a < PROG_WORDS; a++)
		begin
			image[a] = program_word();
		end
		// Guard word keeps the fetch inside the loaded range
		image[PROG_WORDS - 1] = HALT_WORD;
		if (halt_addr >= 0)
		begin
			image[halt_addr] = HALT_WORD;
		end
		for (int a = 0; a < PROG_WORDS; a++)
		begin
			write_word(a, image[a]);
		end
	endtask

	task automatic release_reset();
		rst = 1'b0;
		confirm_bubble();
		check_flag("halted", halted, 1'b0);
		// Memory read edge for address zero
		tick();
		next_addr = 0;
	endtask

	task automatic run_sequential(input int count);
		repeat (count)
		begin
			tick();
			match_fetched(next_addr);
			next_addr++;
		end
	endtask

	// Word at the redirecting PC is dropped, one bubble, then the target
	task automatic take_redirect(input pc_src_t src, input int target);
		pc_src = src;
		jump_target = WORD_W'(target + 1);
		branch_target = WORD_W'(target + 2);
		reg_target = WORD_W'(target + 3);
		case (src)
			PC_JUMP:   jump_target = WORD_W'(target);
			PC_BRANCH: branch_target = WORD_W'(target);
			default:   reg_target = WORD_W'(target);
		endcase
		tick();
		match_fetched(next_addr);
		pc_src = PC_SEQ;
		tick();
		confirm_bubble();
		tick();
		match_fetched(target);
		next_addr = target + 1;
	endtask

	task automatic report_test(input string name);
		if (error_count == test_base)
		begin
			$display("%-12s passed", name);
		end
		else
		begin
			$display("%-12s FAILED with %0d mismatches", name, error_count - test_base);
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic sequential_fetch();
		test_base = error_count;
		load_program(-1);
		release_reset();
		run_sequential(20);
		report_test("sequential");
	endtask

	task automatic redirect_sources();
		test_base = error_count;
		load_program(-1);
		release_reset();
		run_sequential(4);
		take_redirect(PC_JUMP, 40);
		run_sequential(3);
		take_redirect(PC_BRANCH, 12);
		run_sequential(3);
		take_redirect(PC_REG, 27);
		run_sequential(3);
		report_test("redirect");
	endtask

	task automatic stall_hold();
		test_base = error_count;
		load_program(-1);
		release_reset();
		run_sequential(5);
		stall = 1'b1;
		repeat (6)
		begin
			tick();
			match_fetched(next_addr - 1);
		end
		stall = 1'b0;
		run_sequential(8);
		// Single-cycle stall
		stall = 1'b1;
		tick();
		match_fetched(next_addr - 1);
		stall = 1'b0;
		run_sequential(4);
		report_test("stall");
	endtask

	task automatic halt_stop();
		test_base = error_count;
		load_program(HALT_AT);
		release_reset();
		for (int a = 0; a <= HALT_AT; a++)
		begin
			tick();
			match_fetched(a);
			check_flag("halted", halted, a >= HALT_AT - 1);
		end
		// Redirect while halted must not move the stream
		pc_src = PC_JUMP;
		jump_target = WORD_W'(5);
		repeat (6)
		begin
			tick();
			match_fetched(HALT_AT);
			check_flag("halted", halted, 1'b1);
		end
		pc_src = PC_SEQ;
		rst = 1'b1;
		tick();
		check_flag("halted", halted, 1'b0);
		confirm_bubble();
		report_test("halt");
	endtask

	task automatic debug_load();
		int patch_addr [5];
		test_base = error_count;
		patch_addr = '{21, 6, 14, 3, 9};
		load_program(-1);
		// Still in reset; overwrite a few words out of order
		foreach (patch_addr[i])
		begin
			image[patch_addr[i]] = program_word();
			write_word(patch_addr[i], image[patch_addr[i]]);
		end
		release_reset();
		run_sequential(24);
		report_test("debug load");
	endtask

	initial
	begin
		rng_state = 32'd4;
		error_count = 0;
		check_count = 0;
		test_base = 0;
		next_addr = 0;
		rst = 1'b1;
		pc_src = PC_SEQ;
		jump_target = '0;
		branch_target = '0;
		reg_target = '0;
		stall = 1'b0;
		debug_en = 1'b0;
		debug_addr = '0;
		debug_data = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;

		sequential_fetch();
		redirect_sources();
		stall_hold();
		halt_stop();
		debug_load();

		error_count = error_count + u_instruction_fetch.u_fetch_props.assert_failures;
		$display("Checks: %0d, mismatches and assertion failures: %0d", check_count,
			error_count);
		if (error_count == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
